/* all.f */
+incdir+include
logic/secv_pkg.sv
logic/mem_bus_pkg.sv
logic/mem_req_decode.sv
logic/mtag_chk.sv
logic/load_align.sv
logic/mem_access_ctrl.sv
logic/mem_ram.sv
logic/secv_mem_top.sv
dv/tb_secv_mem.sv

/* dv/tb_secv_mem.sv */
// Random testbench for secv_mem_top; one request at a time, addresses stay inside the 8-bit data space
`default_nettype none

`include "secv_defs.svh"

module tb_secv_mem import secv_pkg::*, mem_bus_pkg::*; ();

    localparam int MAX_REQS       = 2000;
    localparam int CYCLES_PER_REQ = 5;
    localparam int CYCLE_LIMIT    = MAX_REQS * CYCLES_PER_REQ + 500;
    localparam int RDY_WAIT_MAX   = 8;

    logic       clk_i = 1'b0;
    logic       rst_i;
    funit_in_t  fu_i;
    funit_out_t fu_o;
    tag_wr_t    tag_wr_i;
    funit_out_t idle_resp;

    // Reference byte memory and one tag per 16-byte granule
    logic [7:0] mem_model [256];
    tag_t       tag_model [16];

    integer seed      = 32'h26be_3fb5;
    int     cycle_cnt = 0;
    int     err_cnt   = 0;
    int     req_cnt   = 0;
    int     test_cnt  = 0;
    int     test_errs;
    int     test_reqs;
    string  test_name;

    logic [3:0] load_ops [7] = '{MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LD,
                                 MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LWU};
    logic [3:0] store_ops [4] = '{MEM_OP_SB, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD};
    logic [3:0] bad_ops [5] = '{4'h7, 4'hc, 4'hd, 4'he, 4'hf};
    logic [3:0] wide_ops [8] = '{MEM_OP_LH, MEM_OP_LW, MEM_OP_LD, MEM_OP_LHU,
                                 MEM_OP_LWU, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD};

    secv_mem_top u_secv_mem_top (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .fu_i     (fu_i),
        .fu_o     (fu_o),
        .tag_wr_i (tag_wr_i)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int rnd(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    function automatic xlen_t rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    // Access width in bytes, 0 for codes outside the operation list
    function automatic int op_bytes(input logic [3:0] op);
        case (op)
            MEM_OP_LB, MEM_OP_LBU, MEM_OP_SB: return 1;
            MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH: return 2;
            MEM_OP_LW, MEM_OP_LWU, MEM_OP_SW: return 4;
            MEM_OP_LD, MEM_OP_SD:             return 8;
            default:                          return 0;
        endcase
    endfunction

    function automatic logic [3:0] any_op();
        int k;
        k = rnd(11);
        if (k < 7) begin
            return load_ops[k];
        end
        return store_ops[k - 7];
    endfunction

    function automatic xlen_t model_load(input logic [3:0] op, input int adr);
        xlen_t v;
        int    n;
        n = op_bytes(op);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = mem_model[adr + i];
        end
        // LB, LH and LW copy the top loaded bit upwards
        if ((op inside {MEM_OP_LB, MEM_OP_LH, MEM_OP_LW}) && v[8*n-1]) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic preload_tag(input int g, input tag_t tag);
        @(posedge clk_i);
        #2;
        tag_wr_i.en  = 1'b1;
        tag_wr_i.adr = tadr_t'(g);
        tag_wr_i.tag = tag;
        @(posedge clk_i);
        #2;
        tag_wr_i.en  = 1'b0;
        tag_model[g] = tag;
    endtask

    task automatic run_req(input logic [3:0] op, input int adr, input xlen_t data,
                           input hart_id_t hart);
        int     n;
        int     g;
        int     lat;
        int     exp_lat;
        logic   store;
        logic   exp_err;
        logic   exp_wb;
        ecode_t exp_ecode;
        xlen_t  exp_res;
        n         = op_bytes(op);
        g         = adr >> 4;
        store     = op inside {MEM_OP_SB, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD};
        exp_err   = 1'b1;
        exp_wb    = 1'b0;
        exp_res   = '0;
        exp_lat   = 2;
        exp_ecode = ECODE_NONE;
        // Priority: operation, alignment, tag owner, address mask
        if (n == 0) begin
            exp_ecode = ECODE_OP_INVALID;
            exp_lat   = 1;
        end else if ((adr % n) != 0) begin
            exp_ecode = store ? ECODE_STORE_MISALIGNED : ECODE_LOAD_MISALIGNED;
            exp_lat   = 1;
        end else if (tag_model[g][15] && (tag_model[g][1:0] != hart)) begin
            exp_ecode = store ? ECODE_MTAG_STORE_INVLD : ECODE_MTAG_LOAD_INVLD;
        end else if ((adr & int'(`SECV_ADR_FAULT_MASK)) != 0) begin
            exp_ecode = store ? ECODE_STORE_ACCESS_FAULT : ECODE_LOAD_ACCESS_FAULT;
        end else begin
            exp_err = 1'b0;
            exp_lat = 3;
            if (!store) begin
                exp_res = model_load(op, adr);
                exp_wb  = 1'b1;
            end
        end

        @(posedge clk_i);
        #2;
        fu_i.ena  = 1'b1;
        fu_i.op   = mem_op_t'(op);
        fu_i.src1 = xlen_t'(adr);
        fu_i.src2 = data;
        fu_i.hart = hart;
        lat = 0;
        @(negedge clk_i);
        while (!fu_o.rdy && lat < RDY_WAIT_MAX) begin
            @(posedge clk_i);
            lat++;
            @(negedge clk_i);
        end
        req_cnt++;
        if (!fu_o.rdy) begin
            $display("%s: op %h at %h got no rdy within %0d cycles", test_name, op, adr, lat);
            err_cnt++;
        end else begin
            if (lat != exp_lat) begin
                $display("Error %s: latency op %h adr %h expected %0d actual %0d",
                         test_name, op, adr, exp_lat, lat);
                err_cnt++;
            end
            if (fu_o.err !== exp_err) begin
                $display("Error %s: err op %h adr %h expected %b actual %b",
                         test_name, op, adr, exp_err, fu_o.err);
                err_cnt++;
            end
            if (fu_o.ecode !== exp_ecode) begin
                $display("Error %s: ecode op %h adr %h expected %0d actual %0d",
                         test_name, op, adr, exp_ecode, fu_o.ecode);
                err_cnt++;
            end
            if (fu_o.res !== exp_res) begin
                $display("Error %s: res op %h adr %h expected %h actual %h",
                         test_name, op, adr, exp_res, fu_o.res);
                err_cnt++;
            end
            if (fu_o.res_wb !== exp_wb) begin
                $display("Error %s: res_wb op %h adr %h expected %b actual %b",
                         test_name, op, adr, exp_wb, fu_o.res_wb);
                err_cnt++;
            end
        end
        if (!exp_err && store) begin
            for (int i = 0; i < n; i++) begin
                mem_model[adr + i] = data[8*i +: 8];
            end
        end

        // Idle cycle with scrambled operands
        @(posedge clk_i);
        #2;
        fu_i.ena  = 1'b0;
        fu_i.op   = mem_op_t'(4'(rnd(16)));
        fu_i.src1 = rnd64();
        @(negedge clk_i);
        if (fu_o !== idle_resp) begin
            $display("%s: fu_o is not at its default while ena is low, got %h", test_name, fu_o);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_cnt;
        test_reqs = req_cnt;
    endtask

    task automatic finish_test();
        test_cnt++;
        $display("Test %s done: %0d requests, %0d errors", test_name, req_cnt - test_reqs,
                 err_cnt - test_errs);
    endtask

    initial begin
        logic [3:0] op;
        int         n;
        int         adr;
        hart_id_t   hart;
        idle_resp       = '0;
        idle_resp.ecode = ECODE_NONE;
        rst_i    = 1'b1;
        fu_i     = '0;
        tag_wr_i = '0;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = 8'h00;
        end
        for (int i = 0; i < 16; i++) begin
            tag_model[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        begin_test("store_load");
        for (int k = 0; k < 40; k++) begin
            op   = store_ops[rnd(4)];
            n    = op_bytes(op);
            adr  = rnd(128) & ~(n - 1);
            hart = hart_id_t'(rnd(4));
            run_req(op, adr, rnd64(), hart);
            for (int j = 0; j < 7; j++) begin
                n = op_bytes(load_ops[j]);
                run_req(load_ops[j], adr & ~(n - 1), rnd64(), hart);
            end
        end
        finish_test();

        begin_test("decode_err");
        for (int k = 0; k < 40; k++) begin
            adr  = rnd(128);
            hart = hart_id_t'(rnd(4));
            if (rnd(2) == 0) begin
                op = bad_ops[rnd(5)];
            end else begin
                op = wide_ops[rnd(8)];
                if ((adr % op_bytes(op)) == 0) begin
                    adr = adr + 1;
                end
            end
            run_req(op, adr, rnd64(), hart);
            run_req(MEM_OP_LD, adr & ~7, '0, hart);
        end
        finish_test();

        begin_test("adr_fault");
        for (int k = 0; k < 30; k++) begin
            op   = any_op();
            n    = op_bytes(op);
            adr  = (128 + rnd(128)) & ~(n - 1);
            hart = hart_id_t'(rnd(4));
            run_req(op, adr, rnd64(), hart);
            // Same offset in the lower half shows no aliased write
            run_req(MEM_OP_LD, adr & 'h78, '0, hart);
        end
        finish_test();

        begin_test("tag_check");
        for (int g = 0; g < 8; g++) begin
            preload_tag(g, tag_t'($random(seed)));
        end
        for (int k = 0; k < 60; k++) begin
            op   = any_op();
            n    = op_bytes(op);
            adr  = rnd(128) & ~(n - 1);
            hart = (rnd(2) == 0) ? tag_model[adr >> 4][1:0] : hart_id_t'(rnd(4));
            run_req(op, adr, rnd64(), hart);
        end
        finish_test();

        begin_test("latency");
        preload_tag(0, 16'h8001);
        preload_tag(1, 16'h0000);
        preload_tag(8, 16'h8003);
        for (int k = 0; k < 20; k++) begin
            run_req(bad_ops[rnd(5)], rnd(128), rnd64(), hart_id_t'(rnd(4)));
            run_req(MEM_OP_LW, 4 * rnd(32) + 2, rnd64(), hart_id_t'(rnd(4)));
            run_req(MEM_OP_SD, 144 + 8 * rnd(14), rnd64(), hart_id_t'(rnd(4)));
            // Tagged granule above the mask, tag fault wins
            run_req(MEM_OP_LH, 128 + 2 * rnd(8), '0, 2'd0);
            run_req(any_op(), 8, rnd64(), 2'd2);
            run_req(MEM_OP_SW, 16 + 4 * rnd(4), rnd64(), hart_id_t'(rnd(4)));
            run_req(MEM_OP_LWU, 16 + 4 * rnd(4), '0, hart_id_t'(rnd(4)));
        end
        finish_test();

        $display("Summary: %0d tests, %0d requests, %0d errors", test_cnt, req_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* include/secv_defs.svh */
// Sizes of the SEC-V memory unit; the data RAM is 256 bytes and one 16-bit tag covers 16 bytes
`ifndef SECV_DEFS_SVH
`define SECV_DEFS_SVH

// Register and data path width
`define SECV_XLEN 64

// Byte address width of the data memory, 32 doublewords
`define SECV_ADR_WIDTH 8

// Width of one memory tag
// Bit 15 marks a valid tag, the low bits hold the owner hart
`define SECV_TLEN 16

// Bytes per tag granule as a power of two
`define SECV_TAG_GRANULE_LOG2 4

// Harts sharing the memory
`define SECV_HARTS 4

// Any address with one of these bits set raises an access fault
`define SECV_ADR_FAULT_MASK 8'h80

`endif

/* logic/load_align.sv */
// Load result formatting; expects an aligned lane offset so the value never crosses the word
`default_nettype none

`include "secv_defs.svh"

module load_align import secv_pkg::*; (
    input  xlen_t      raw_i,
    input  logic [2:0] lane_i,
    input  logic [1:0] size_i,
    input  logic       signed_i,
    output xlen_t      res_o
);
    xlen_t shifted;

    // Move the addressed bytes down to lane 0
    assign shifted = raw_i >> {lane_i, 3'b000};

    always_comb begin
        case (size_i)
            2'd0: begin
                res_o = {{(`SECV_XLEN-8){signed_i & shifted[7]}}, shifted[7:0]};
            end
            2'd1: begin
                res_o = {{(`SECV_XLEN-16){signed_i & shifted[15]}}, shifted[15:0]};
            end
            2'd2: begin
                res_o = {{(`SECV_XLEN-32){signed_i & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                res_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mem_access_ctrl.sv */
// Single-request sequencer; expects ena and operands held until rdy and memories that ack in one cycle
`default_nettype none

`include "secv_defs.svh"

module mem_access_ctrl import secv_pkg::*, mem_bus_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  funit_in_t  fu_i,
    input  bus_req_t   bus_i,
    input  logic [1:0] size_i,
    input  logic       signed_i,
    input  logic       load_i,
    input  logic       dec_err_i,
    input  ecode_t     dec_ecode_i,
    output bus_req_t   tbus_o,
    input  tag_t       tdat_i,
    input  logic       tack_i,
    output bus_req_t   dbus_o,
    input  logic       dack_i,
    input  xlen_t      res_i,
    output funit_out_t fu_o
);
    typedef enum logic [1:0] {
        IDLE,
        TAG,
        ACCESS,
        DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   err_q;
    logic   err_d;
    ecode_t ecode_q;
    ecode_t ecode_d;
    logic   tag_start;
    logic   tag_done;
    logic   tag_err;
    logic   adr_fault;
    logic   rdy;
    xlen_t  load_res;

    assign adr_fault = (bus_i.adr & dadr_t'(`SECV_ADR_FAULT_MASK)) != '0;
    assign tag_start = (state_q == IDLE) && fu_i.ena && !dec_err_i;

    mtag_chk u_mtag_chk (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (tag_start),
        .adr_i   (bus_i.adr),
        .hart_i  (fu_i.hart),
        .tbus_o  (tbus_o),
        .tdat_i  (tdat_i),
        .tack_i  (tack_i),
        .done_o  (tag_done),
        .err_o   (tag_err)
    );

    load_align u_load_align (
        .raw_i    (res_i),
        .lane_i   (bus_i.adr[2:0]),
        .size_i   (size_i),
        .signed_i (signed_i),
        .res_o    (load_res)
    );

    always_comb begin
        state_d = state_q;
        err_d   = err_q;
        ecode_d = ecode_q;
        case (state_q)
            IDLE: begin
                if (fu_i.ena && dec_err_i) begin
                    state_d = DONE;
                    err_d   = 1'b1;
                    ecode_d = dec_ecode_i;
                end else if (fu_i.ena) begin
                    state_d = TAG;
                    err_d   = 1'b0;
                    ecode_d = ECODE_NONE;
                end
            end
            TAG: begin
                // Tag fault wins over address fault
                if (tag_done && tag_err) begin
                    state_d = DONE;
                    err_d   = 1'b1;
                    ecode_d = load_i ? ECODE_MTAG_LOAD_INVLD : ECODE_MTAG_STORE_INVLD;
                end else if (tag_done && adr_fault) begin
                    state_d = DONE;
                    err_d   = 1'b1;
                    ecode_d = load_i ? ECODE_LOAD_ACCESS_FAULT : ECODE_STORE_ACCESS_FAULT;
                end else if (tag_done) begin
                    state_d = ACCESS;
                end
            end
            ACCESS:  state_d = DONE;
            DONE: begin
                if (rdy) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
            ecode_q <= ECODE_NONE;
        end else begin
            state_q <= state_d;
            err_q   <= err_d;
            ecode_q <= ecode_d;
        end
    end

    // One strobe per access
    always_comb begin
        dbus_o = '0;
        if (state_q == ACCESS) begin
            dbus_o     = bus_i;
            dbus_o.cyc = 1'b1;
            dbus_o.stb = 1'b1;
        end
    end

    assign rdy = (state_q == DONE) && (err_q || dack_i);

    always_comb begin
        fu_o = funit_out_default();
        if (fu_i.ena && rdy) begin
            fu_o.rdy   = 1'b1;
            fu_o.err   = err_q;
            fu_o.ecode = ecode_q;
            if (load_i && !err_q) begin
                fu_o.res    = load_res;
                fu_o.res_wb = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_bus_pkg.sv */
// Bus-side types; data and tag buses share one request struct carrying byte addresses
`default_nettype none

`include "secv_defs.svh"

package mem_bus_pkg;

    typedef logic [`SECV_ADR_WIDTH-1:0] dadr_t;
    typedef logic [`SECV_XLEN/8-1:0] sel_t;
    typedef logic [`SECV_XLEN-1:0] bdat_t;
    typedef logic [`SECV_TLEN-1:0] tag_t;
    typedef logic [`SECV_ADR_WIDTH-`SECV_TAG_GRANULE_LOG2-1:0] tadr_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        dadr_t adr;
        bdat_t dat;
    } bus_req_t;

    // Tag preload write, addressed by granule index
    typedef struct packed {
        logic  en;
        tadr_t adr;
        tag_t  tag;
    } tag_wr_t;

endpackage

`default_nettype wire

/* logic/mem_ram.sv */
// Byte-addressed RAM of DW-bit words; a bus access wins over a preload write in the same cycle
`default_nettype none

`include "secv_defs.svh"

module mem_ram import mem_bus_pkg::*; #(
    parameter int DW = `SECV_XLEN
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  bus_req_t      req_i,
    input  tag_wr_t       wr_i,
    output logic [DW-1:0] dat_o,
    output logic          ack_o
);
    localparam int NB  = DW / 8;
    localparam int OFS = $clog2(NB);
    localparam int AW  = `SECV_ADR_WIDTH - OFS;

    logic [DW-1:0] mem [2**AW];
    logic [AW-1:0] idx;
    logic          acc;

    // Word index from the byte address
    assign idx = req_i.adr[`SECV_ADR_WIDTH-1:OFS];
    assign acc = req_i.cyc && req_i.stb;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**AW; i++) begin
                mem[i] <= '0;
            end
            dat_o <= '0;
            ack_o <= 1'b0;
        end else begin
            ack_o <= acc;
            if (acc && req_i.we) begin
                for (int b = 0; b < NB; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end else if (acc) begin
                dat_o <= mem[idx];
            end else if (wr_i.en) begin
                mem[AW'(wr_i.adr)] <= DW'(wr_i.tag);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_req_decode.sv */
// Pure logic request decode; its outputs are only meaningful while the operands are held steady
`default_nettype none

module mem_req_decode import secv_pkg::*, mem_bus_pkg::*; (
    input  funit_in_t  fu_i,
    output bus_req_t   bus_o,
    output logic [1:0] size_o,
    output logic       signed_o,
    output logic       load_o,
    output logic       dec_err_o,
    output ecode_t     dec_ecode_o
);
    logic [2:0] lane;
    logic       valid_op;
    logic       misaligned;
    sel_t       sel_base;

    assign lane = fu_i.src1[2:0];

    // Size is log2 of the access width in bytes
    always_comb begin
        valid_op = 1'b1;
        size_o   = 2'd0;
        signed_o = 1'b0;
        load_o   = 1'b1;
        case (fu_i.op)
            MEM_OP_LB:  signed_o = 1'b1;
            MEM_OP_LH: begin
                size_o   = 2'd1;
                signed_o = 1'b1;
            end
            MEM_OP_LW: begin
                size_o   = 2'd2;
                signed_o = 1'b1;
            end
            MEM_OP_LD:  size_o = 2'd3;
            MEM_OP_LBU: size_o = 2'd0;
            MEM_OP_LHU: size_o = 2'd1;
            MEM_OP_LWU: size_o = 2'd2;
            MEM_OP_SB:  load_o = 1'b0;
            MEM_OP_SH: begin
                size_o = 2'd1;
                load_o = 1'b0;
            end
            MEM_OP_SW: begin
                size_o = 2'd2;
                load_o = 1'b0;
            end
            MEM_OP_SD: begin
                size_o = 2'd3;
                load_o = 1'b0;
            end
            default:    valid_op = 1'b0;
        endcase
    end

    // Natural alignment per size
    always_comb begin
        case (size_o)
            2'd0: begin
                sel_base   = 8'h01;
                misaligned = 1'b0;
            end
            2'd1: begin
                sel_base   = 8'h03;
                misaligned = lane[0];
            end
            2'd2: begin
                sel_base   = 8'h0f;
                misaligned = |lane[1:0];
            end
            default: begin
                sel_base   = 8'hff;
                misaligned = |lane;
            end
        endcase
    end

    // Lanes follow the low address bits, strobes are added by the sequencer
    always_comb begin
        bus_o     = '0;
        bus_o.we  = !load_o;
        bus_o.sel = sel_base << lane;
        bus_o.adr = dadr_t'(fu_i.src1);
        bus_o.dat = fu_i.src2 << {lane, 3'b000};
    end

    always_comb begin
        dec_err_o   = 1'b0;
        dec_ecode_o = ECODE_NONE;
        if (!valid_op) begin
            dec_err_o   = 1'b1;
            dec_ecode_o = ECODE_OP_INVALID;
        end else if (misaligned) begin
            dec_err_o   = 1'b1;
            dec_ecode_o = load_o ? ECODE_LOAD_MISALIGNED : ECODE_STORE_MISALIGNED;
        end
    end

endmodule

`default_nettype wire

/* logic/mtag_chk.sv */
// Tag lookup for one granule; needs a tag RAM with registered data that acks one cycle after stb
`default_nettype none

`include "secv_defs.svh"

module mtag_chk import secv_pkg::*, mem_bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     start_i,
    input  dadr_t    adr_i,
    input  hart_id_t hart_i,
    output bus_req_t tbus_o,
    input  tag_t     tdat_i,
    input  logic     tack_i,
    output logic     done_o,
    output logic     err_o
);
    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t   state_q;
    state_t   state_d;
    tadr_t    tadr;
    logic     tag_valid;
    hart_id_t tag_owner;

    // Granule index of the data address
    assign tadr = tadr_t'(adr_i >> `SECV_TAG_GRANULE_LOG2);

    // Tag RAM is byte addressed like the data bus
    always_comb begin
        tbus_o     = '0;
        tbus_o.cyc = (state_q == IDLE) && start_i;
        tbus_o.stb = (state_q == IDLE) && start_i;
        tbus_o.sel = sel_t'({(`SECV_TLEN/8){1'b1}});
        tbus_o.adr = dadr_t'(tadr) << $clog2(`SECV_TLEN / 8);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (tack_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Tag word comes straight from the RAM output register
    assign tag_valid = tdat_i[`SECV_TLEN-1];
    assign tag_owner = tdat_i[$bits(hart_id_t)-1:0];

    assign done_o = (state_q == WAIT) && tack_i;
    assign err_o  = done_o && tag_valid && (tag_owner != hart_i);

endmodule

`default_nettype wire

/* logic/secv_mem_top.sv */
// Memory function unit with its data and tag RAMs; tag_wr_i may only be used while fu_i.ena is low
`default_nettype none

`include "secv_defs.svh"

module secv_mem_top import secv_pkg::*, mem_bus_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  funit_in_t  fu_i,
    output funit_out_t fu_o,
    input  tag_wr_t    tag_wr_i
);
    bus_req_t   dec_bus;
    bus_req_t   dbus;
    bus_req_t   tbus;
    logic [1:0] dec_size;
    logic       dec_signed;
    logic       dec_load;
    logic       dec_err;
    ecode_t     dec_ecode;
    xlen_t      dram_dat;
    logic       dram_ack;
    tag_t       tram_dat;
    logic       tram_ack;

    mem_req_decode u_mem_req_decode (
        .fu_i        (fu_i),
        .bus_o       (dec_bus),
        .size_o      (dec_size),
        .signed_o    (dec_signed),
        .load_o      (dec_load),
        .dec_err_o   (dec_err),
        .dec_ecode_o (dec_ecode)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .fu_i        (fu_i),
        .bus_i       (dec_bus),
        .size_i      (dec_size),
        .signed_i    (dec_signed),
        .load_i      (dec_load),
        .dec_err_i   (dec_err),
        .dec_ecode_i (dec_ecode),
        .tbus_o      (tbus),
        .tdat_i      (tram_dat),
        .tack_i      (tram_ack),
        .dbus_o      (dbus),
        .dack_i      (dram_ack),
        .res_i       (dram_dat),
        .fu_o        (fu_o)
    );

    // Data RAM has no preload path
    mem_ram #(.DW(`SECV_XLEN)) u_dram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (dbus),
        .wr_i  (tag_wr_t'('0)),
        .dat_o (dram_dat),
        .ack_o (dram_ack)
    );

    mem_ram #(.DW(`SECV_TLEN)) u_tram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (tbus),
        .wr_i  (tag_wr_i),
        .dat_o (tram_dat),
        .ack_o (tram_ack)
    );

endmodule

`default_nettype wire

/* logic/secv_pkg.sv */
// Core-side types of the memory unit; only the 11 RV64 integer loads and stores are encoded
`default_nettype none

`include "secv_defs.svh"

package secv_pkg;

    typedef logic [`SECV_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`SECV_HARTS)-1:0] hart_id_t;

    // Bit 3 marks a store, codes 7 and 12 to 15 are unused
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'h0,
        MEM_OP_LH  = 4'h1,
        MEM_OP_LW  = 4'h2,
        MEM_OP_LD  = 4'h3,
        MEM_OP_LBU = 4'h4,
        MEM_OP_LHU = 4'h5,
        MEM_OP_LWU = 4'h6,
        MEM_OP_SB  = 4'h8,
        MEM_OP_SH  = 4'h9,
        MEM_OP_SW  = 4'ha,
        MEM_OP_SD  = 4'hb
    } mem_op_t;

    // Standard RISC-V cause numbers, tag faults in the custom range
    typedef enum logic [4:0] {
        ECODE_OP_INVALID         = 5'd2,
        ECODE_LOAD_MISALIGNED    = 5'd4,
        ECODE_LOAD_ACCESS_FAULT  = 5'd5,
        ECODE_STORE_MISALIGNED   = 5'd6,
        ECODE_STORE_ACCESS_FAULT = 5'd7,
        ECODE_MTAG_LOAD_INVLD    = 5'd24,
        ECODE_MTAG_STORE_INVLD   = 5'd25,
        ECODE_NONE               = 5'd31
    } ecode_t;

    typedef struct packed {
        logic     ena;
        mem_op_t  op;
        xlen_t    src1;
        xlen_t    src2;
        hart_id_t hart;
    } funit_in_t;

    typedef struct packed {
        logic   rdy;
        logic   err;
        ecode_t ecode;
        xlen_t  res;
        logic   res_wb;
    } funit_out_t;

    // Idle response of a function unit
    function automatic funit_out_t funit_out_default();
        funit_out_t o;
        o       = '0;
        o.ecode = ECODE_NONE;
        return o;
    endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs tb_secv_mem with Verilator, pass is read from sim.log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_secv_mem -f all.f -o sim_secv_mem

./obj_dir/sim_secv_mem | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "Simulation log shows a pass"
else
    echo "Simulation log shows no pass"
    exit 1
fi
